/* verilog/erdma_pkg.sv */
`default_nettype none

package erdma_pkg;

  // ======================================================================
  // widths
  // ======================================================================
  localparam int ADDR_W = 32;              // byte address
  localparam int DATA_W = 64;              // one response word
  localparam int HALF_W = 32;              // one alu / mul operand
  localparam int DIM_W  = 13;              // width and height fields

  // request payload is {word count, address}
  localparam int REQ_W = ADDR_W + DIM_W;

  // context entry is {last, word count}
  localparam int CQ_W = DIM_W + 1;

  // ======================================================================
  // enums
  // ======================================================================
  typedef enum logic [1:0] {
    USE_MUL  = 2'd0,                       // words go to the mul stream only
    USE_ALU  = 2'd1,                       // words go to the alu stream only
    USE_BOTH = 2'd2                        // low half to alu, high half to mul
  } erdma_use_e;

  typedef enum logic {
    IG_IDLE = 1'b0,
    IG_REQ  = 1'b1                         // walking the lines of a layer
  } ig_state_e;

  typedef enum logic {
    EG_IDLE = 1'b0,                        // waiting for a context entry
    EG_RUN  = 1'b1                         // draining the words of one line
  } eg_state_e;

endpackage

`default_nettype wire

/* verilog/erdma_fifo.sv */
`default_nettype none

module erdma_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 16
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  input  wire               wr_valid,
  output logic              wr_ready,
  input  wire [WIDTH-1:0]   wr_pd,
  output logic              rd_valid,
  input  wire               rd_ready,
  output logic [WIDTH-1:0]  rd_pd
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_fire;
  logic             rd_fire;

  assign wr_ready = (count != CNT_W'(DEPTH));   // full means not ready
  assign rd_valid = (count != '0);
  assign rd_pd    = mem[rd_ptr];                // head straight from storage flops
  assign wr_fire  = wr_valid & wr_ready;
  assign rd_fire  = rd_valid & rd_ready;

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_fire & !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire & !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/erdma_ig.sv */
`default_nettype none

module erdma_ig import erdma_pkg::*; #(
  parameter int LAT_DEPTH = 32
) (
  input  wire               nvdla_core_clk,
  input  wire               nvdla_core_rstn,
  input  wire               op_load,
  input  wire [ADDR_W-1:0]  base_addr,
  input  wire [ADDR_W-1:0]  line_stride,
  input  wire [DIM_W-1:0]   width,
  input  wire [DIM_W-1:0]   height,
  input  wire               perf_dma_en,
  input  wire               cdt_pop,
  output logic              dma_rd_req_valid,
  output logic [REQ_W-1:0]  dma_rd_req_pd,
  input  wire               dma_rd_req_ready,
  output logic              ig2cq_valid,
  output logic [CQ_W-1:0]   ig2cq_pd,
  input  wire               ig2cq_ready,
  output logic [31:0]       stall_cnt
);

  ig_state_e          state;
  logic [ADDR_W-1:0]  line_addr;
  logic [DIM_W-1:0]   line_cnt;
  logic [DIM_W-1:0]   credit;
  logic [DIM_W-1:0]   cdt_sub;
  logic [DIM_W-1:0]   cdt_add;
  logic               cdt_ok;
  logic               last_line;
  logic               req_issue;

  // ======================================================================
  // request issue
  // ======================================================================
  assign cdt_ok    = (credit >= width);              // whole line fits in lat fifo
  assign last_line = (line_cnt == height - 1'b1);

  // credits and cq room only grow while waiting, so valid holds until taken
  assign dma_rd_req_valid = (state == IG_REQ) & cdt_ok & ig2cq_ready;
  assign ig2cq_valid      = (state == IG_REQ) & cdt_ok & dma_rd_req_ready;
  assign req_issue        = dma_rd_req_valid & dma_rd_req_ready;

  assign dma_rd_req_pd = {width, line_addr};
  assign ig2cq_pd      = {last_line, width};

  // line walker
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state     <= IG_IDLE;
      line_cnt  <= '0;
      line_addr <= '0;
    end else begin
      case (state)
        IG_IDLE: begin
          if (op_load) begin
            state     <= IG_REQ;
            line_cnt  <= '0;
            line_addr <= base_addr;
          end
        end
        IG_REQ: begin
          if (req_issue) begin
            line_cnt  <= line_cnt + 1'b1;
            line_addr <= line_addr + line_stride;   // next surface line
            if (last_line) begin
              state <= IG_IDLE;
            end
          end
        end
        default: state <= IG_IDLE;
      endcase
    end
  end

  // ======================================================================
  // credits and perf
  // ======================================================================
  assign cdt_sub = req_issue ? width : '0;
  assign cdt_add = cdt_pop ? DIM_W'(1) : '0;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      credit <= DIM_W'(LAT_DEPTH);                   // lat fifo starts empty
    end else begin
      credit <= credit - cdt_sub + cdt_add;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_load) begin
      stall_cnt <= '0;                               // new layer, new count
    end else if (perf_dma_en & dma_rd_req_valid & !dma_rd_req_ready) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/erdma_eg.sv */
`default_nettype none

module erdma_eg import erdma_pkg::*; (
  input  wire                nvdla_core_clk,
  input  wire                nvdla_core_rstn,
  input  wire                op_load,
  input  wire erdma_use_e    data_use,
  input  wire                cq2eg_valid,
  output logic               cq2eg_ready,
  input  wire [CQ_W-1:0]     cq2eg_pd,
  input  wire                lat_valid,
  output logic               lat_ready,
  input  wire [DATA_W-1:0]   lat_pd,
  output logic               cdt_pop,
  output logic               alu_valid,
  input  wire                alu_ready,
  output logic [HALF_W-1:0]  alu_pd,
  output logic               mul_valid,
  input  wire                mul_ready,
  output logic [HALF_W-1:0]  mul_pd,
  output logic               done
);

  eg_state_e          state;
  erdma_use_e         use_q;
  logic [DIM_W-1:0]   words_left;
  logic               last_q;
  logic               busy;              // head word is on the outputs
  logic               half_sel;          // 1 once the low half has gone
  logic               alu_taken;
  logic               mul_taken;
  logic               alu_en;
  logic               mul_en;
  logic               split;
  logic               beat_last;
  logic               alu_fire;
  logic               mul_fire;
  logic               word_done;
  logic               load_word;
  logic               entry_end;

  // ======================================================================
  // unpack rules
  // ======================================================================
  assign alu_en    = (use_q != USE_MUL);
  assign mul_en    = (use_q != USE_ALU);
  assign split     = (use_q != USE_BOTH);         // one stream, two beats per word
  assign beat_last = !split | half_sel;
  assign alu_fire  = alu_valid & alu_ready;
  assign mul_fire  = mul_valid & mul_ready;

  assign load_word = (state == EG_RUN) & !busy & lat_valid;
  assign word_done = busy & (alu_taken | (alu_fire & beat_last))
                          & (mul_taken | (mul_fire & beat_last));
  assign entry_end = word_done & (words_left == DIM_W'(1));

  assign lat_ready   = word_done;                 // pop once both halves are gone
  assign cdt_pop     = lat_valid & lat_ready;
  assign cq2eg_ready = (state == EG_IDLE);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      use_q <= USE_ALU;
    end else if (op_load) begin
      use_q <= data_use;                          // mode fixed for the layer
    end
  end

  // ======================================================================
  // line tracking
  // ======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state      <= EG_IDLE;
      words_left <= '0;
      last_q     <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= entry_end & last_q;                 // layer finished
      case (state)
        EG_IDLE: begin
          if (cq2eg_valid) begin
            words_left <= cq2eg_pd[DIM_W-1:0];
            last_q     <= cq2eg_pd[DIM_W];
            state      <= EG_RUN;
          end
        end
        EG_RUN: begin
          if (word_done) begin
            words_left <= words_left - 1'b1;
            if (entry_end) begin
              state <= EG_IDLE;
            end
          end
        end
        default: state <= EG_IDLE;
      endcase
    end
  end

  // ======================================================================
  // output beats
  // ======================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      busy      <= 1'b0;
      half_sel  <= 1'b0;
      alu_taken <= 1'b0;
      mul_taken <= 1'b0;
      alu_valid <= 1'b0;
      mul_valid <= 1'b0;
    end else if (load_word) begin
      busy      <= 1'b1;
      half_sel  <= 1'b0;
      alu_taken <= !alu_en;                       // idle stream counts as taken
      mul_taken <= !mul_en;
      alu_valid <= alu_en;
      mul_valid <= mul_en;
    end else if (busy) begin
      if (word_done) begin
        busy <= 1'b0;
      end
      if ((alu_fire | mul_fire) & !beat_last) begin
        half_sel <= 1'b1;
      end
      if (alu_fire & beat_last) begin
        alu_valid <= 1'b0;
        alu_taken <= 1'b1;
      end
      if (mul_fire & beat_last) begin
        mul_valid <= 1'b0;
        mul_taken <= 1'b1;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load_word) begin
      alu_pd <= lat_pd[HALF_W-1:0];
      mul_pd <= split ? lat_pd[HALF_W-1:0] : lat_pd[DATA_W-1:HALF_W];
    end else begin
      if (alu_fire & !beat_last) begin
        alu_pd <= lat_pd[DATA_W-1:HALF_W];        // high half follows
      end
      if (mul_fire & !beat_last) begin
        mul_pd <= lat_pd[DATA_W-1:HALF_W];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/erdma_top.sv */
`default_nettype none

module erdma_top import erdma_pkg::*; #(
  parameter int LAT_DEPTH = 32,
  parameter int CQ_DEPTH  = 8
) (
  input  wire                nvdla_core_clk,
  input  wire                nvdla_core_rstn,
  input  wire                op_en,
  input  wire erdma_use_e    data_use,
  input  wire                perf_dma_en,
  input  wire [ADDR_W-1:0]   base_addr,
  input  wire [ADDR_W-1:0]   line_stride,
  input  wire [DIM_W-1:0]    width,
  input  wire [DIM_W-1:0]    height,
  output logic               done,
  output logic [31:0]        stall_cnt,
  output logic               rd_req_valid,
  output logic [REQ_W-1:0]   rd_req_pd,
  input  wire                rd_req_ready,
  output logic               rd_cdt_lat_fifo_pop,
  input  wire                rd_rsp_valid,
  input  wire [DATA_W-1:0]   rd_rsp_pd,
  output logic               rd_rsp_ready,
  output logic               alu_valid,
  output logic [HALF_W-1:0]  alu_pd,
  input  wire                alu_ready,
  output logic               mul_valid,
  output logic [HALF_W-1:0]  mul_pd,
  input  wire                mul_ready
);

  logic               layer_process;
  logic               op_load;
  logic               ig2cq_valid;
  logic               ig2cq_ready;
  logic [CQ_W-1:0]    ig2cq_pd;
  logic               cq2eg_valid;
  logic               cq2eg_ready;
  logic [CQ_W-1:0]    cq2eg_pd;
  logic               lat_fifo_rd_valid;
  logic               lat_fifo_rd_ready;
  logic [DATA_W-1:0]  lat_fifo_rd_pd;
  logic               cdt_lat_fifo_pop;

  // ======================================================================
  // layer switch
  // ======================================================================
  assign op_load = op_en & !layer_process;        // start only between layers

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_process <= 1'b0;
    end else if (op_load) begin
      layer_process <= 1'b1;
    end else if (done) begin
      layer_process <= 1'b0;
    end
  end

  assign rd_cdt_lat_fifo_pop = cdt_lat_fifo_pop;

  // ======================================================================
  // datapath
  // ======================================================================
  erdma_ig #(.LAT_DEPTH(LAT_DEPTH)) u_ig (
     .nvdla_core_clk   (nvdla_core_clk)
    ,.nvdla_core_rstn  (nvdla_core_rstn)
    ,.op_load          (op_load)
    ,.base_addr        (base_addr)
    ,.line_stride      (line_stride)
    ,.width            (width)
    ,.height           (height)
    ,.perf_dma_en      (perf_dma_en)
    ,.cdt_pop          (cdt_lat_fifo_pop)
    ,.dma_rd_req_valid (rd_req_valid)
    ,.dma_rd_req_pd    (rd_req_pd)
    ,.dma_rd_req_ready (rd_req_ready)
    ,.ig2cq_valid      (ig2cq_valid)
    ,.ig2cq_pd         (ig2cq_pd)
    ,.ig2cq_ready      (ig2cq_ready)
    ,.stall_cnt        (stall_cnt)
  );

  erdma_fifo #(.DEPTH(CQ_DEPTH), .WIDTH(CQ_W)) u_cq (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.nvdla_core_rstn (nvdla_core_rstn)
    ,.wr_valid        (ig2cq_valid)
    ,.wr_ready        (ig2cq_ready)
    ,.wr_pd           (ig2cq_pd)
    ,.rd_valid        (cq2eg_valid)
    ,.rd_ready        (cq2eg_ready)
    ,.rd_pd           (cq2eg_pd)
  );

  // credits keep this from filling, so rd_rsp_ready stays high
  erdma_fifo #(.DEPTH(LAT_DEPTH), .WIDTH(DATA_W)) u_lat_fifo (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.nvdla_core_rstn (nvdla_core_rstn)
    ,.wr_valid        (rd_rsp_valid)
    ,.wr_ready        (rd_rsp_ready)
    ,.wr_pd           (rd_rsp_pd)
    ,.rd_valid        (lat_fifo_rd_valid)
    ,.rd_ready        (lat_fifo_rd_ready)
    ,.rd_pd           (lat_fifo_rd_pd)
  );

  erdma_eg u_eg (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.nvdla_core_rstn (nvdla_core_rstn)
    ,.op_load         (op_load)
    ,.data_use        (data_use)
    ,.cq2eg_valid     (cq2eg_valid)
    ,.cq2eg_ready     (cq2eg_ready)
    ,.cq2eg_pd        (cq2eg_pd)
    ,.lat_valid       (lat_fifo_rd_valid)
    ,.lat_ready       (lat_fifo_rd_ready)
    ,.lat_pd          (lat_fifo_rd_pd)
    ,.cdt_pop         (cdt_lat_fifo_pop)
    ,.alu_valid       (alu_valid)
    ,.alu_ready       (alu_ready)
    ,.alu_pd          (alu_pd)
    ,.mul_valid       (mul_valid)
    ,.mul_ready       (mul_ready)
    ,.mul_pd          (mul_pd)
    ,.done            (done)
  );

endmodule

`default_nettype wire

/* verif/erdma_assertions.sv */
`default_nettype none

module erdma_assertions import erdma_pkg::*; (
  input wire               nvdla_core_clk,
  input wire               nvdla_core_rstn,
  input wire               rd_req_valid,
  input wire               rd_req_ready,
  input wire [REQ_W-1:0]   rd_req_pd,
  input wire               rd_rsp_valid,
  input wire               rd_rsp_ready,
  input wire               alu_valid,
  input wire               alu_ready,
  input wire [HALF_W-1:0]  alu_pd,
  input wire               mul_valid,
  input wire               mul_ready,
  input wire [HALF_W-1:0]  mul_pd,
  input wire               done
);

  int fail_cnt = 0;                        // seen by the testbench

  a_req_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_pd))
    else begin
      $error("read request dropped or changed while waiting for ready");
      fail_cnt = fail_cnt + 1;
    end

  a_rsp_taken: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    rd_rsp_valid |-> rd_rsp_ready)
    else begin
      $error("read response refused by the latency FIFO");
      fail_cnt = fail_cnt + 1;
    end

  a_alu_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    alu_valid && !alu_ready |=> alu_valid && $stable(alu_pd))
    else begin
      $error("alu operand dropped or changed while waiting for ready");
      fail_cnt = fail_cnt + 1;
    end

  a_mul_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mul_valid && !mul_ready |=> mul_valid && $stable(mul_pd))
    else begin
      $error("mul operand dropped or changed while waiting for ready");
      fail_cnt = fail_cnt + 1;
    end

  a_done_pulse: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    done |=> !done)
    else begin
      $error("done held longer than one cycle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

/* verif/erdma_tb.sv */
`default_nettype none

module erdma_tb import erdma_pkg::*; ();

  localparam int LAT_DEPTH      = 32;
  localparam int CQ_DEPTH       = 8;
  localparam int TOTAL_WORDS    = 4*3 + 4*3 + 8*4 + 16*3 + 32*2;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 40;

  logic               nvdla_core_clk;
  logic               nvdla_core_rstn;
  logic               op_en;
  erdma_use_e         data_use;
  logic               perf_dma_en;
  logic [ADDR_W-1:0]  base_addr;
  logic [ADDR_W-1:0]  line_stride;
  logic [DIM_W-1:0]   width;
  logic [DIM_W-1:0]   height;
  logic               done;
  logic [31:0]        stall_cnt;
  logic               rd_req_valid;
  logic [REQ_W-1:0]   rd_req_pd;
  logic               rd_req_ready = 1'b0;
  logic               rd_cdt_lat_fifo_pop;
  logic               rd_rsp_valid = 1'b0;
  logic [DATA_W-1:0]  rd_rsp_pd = '0;
  logic               rd_rsp_ready;
  logic               alu_valid;
  logic [HALF_W-1:0]  alu_pd;
  logic               alu_ready = 1'b0;
  logic               mul_valid;
  logic [HALF_W-1:0]  mul_pd;
  logic               mul_ready = 1'b0;

  logic               out_rand;                // random ready on alu / mul
  logic               hold_req;                // memory mostly refuses requests
  logic [15:0]        lfsr_state = 16'd90;
  logic [DATA_W-1:0]  pending[$];              // words the memory still owes
  logic [HALF_W-1:0]  exp_alu[$];
  logic [HALF_W-1:0]  exp_mul[$];
  int                 req_line = 0;
  int                 outstanding = 0;
  int                 tb_stall = 0;
  int                 alu_seen = 0;            // cycles with alu_valid in this layer
  int                 mul_seen = 0;
  int                 layers_started = 0;
  int                 done_cnt = 0;

  erdma_top #(.LAT_DEPTH(LAT_DEPTH), .CQ_DEPTH(CQ_DEPTH)) erdma_top_inst (
     .nvdla_core_clk      (nvdla_core_clk)
    ,.nvdla_core_rstn     (nvdla_core_rstn)
    ,.op_en               (op_en)
    ,.data_use            (data_use)
    ,.perf_dma_en         (perf_dma_en)
    ,.base_addr           (base_addr)
    ,.line_stride         (line_stride)
    ,.width               (width)
    ,.height              (height)
    ,.done                (done)
    ,.stall_cnt           (stall_cnt)
    ,.rd_req_valid        (rd_req_valid)
    ,.rd_req_pd           (rd_req_pd)
    ,.rd_req_ready        (rd_req_ready)
    ,.rd_cdt_lat_fifo_pop (rd_cdt_lat_fifo_pop)
    ,.rd_rsp_valid        (rd_rsp_valid)
    ,.rd_rsp_pd           (rd_rsp_pd)
    ,.rd_rsp_ready        (rd_rsp_ready)
    ,.alu_valid           (alu_valid)
    ,.alu_pd              (alu_pd)
    ,.alu_ready           (alu_ready)
    ,.mul_valid           (mul_valid)
    ,.mul_pd              (mul_pd)
    ,.mul_ready           (mul_ready)
  );

  bind erdma_top erdma_assertions u_erdma_assertions (
     .nvdla_core_clk  (nvdla_core_clk)
    ,.nvdla_core_rstn (nvdla_core_rstn)
    ,.rd_req_valid    (rd_req_valid)
    ,.rd_req_ready    (rd_req_ready)
    ,.rd_req_pd       (rd_req_pd)
    ,.rd_rsp_valid    (rd_rsp_valid)
    ,.rd_rsp_ready    (rd_rsp_ready)
    ,.alu_valid       (alu_valid)
    ,.alu_ready       (alu_ready)
    ,.alu_pd          (alu_pd)
    ,.mul_valid       (mul_valid)
    ,.mul_ready       (mul_ready)
    ,.mul_pd          (mul_pd)
    ,.done            (done)
  );

  // ======================================================================
  // helpers
  // ======================================================================
  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_fault(input string msg);
    $display("failure at time %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_operand(input string what, input logic [HALF_W-1:0] got,
                               input logic [HALF_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s operand is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_use(input erdma_use_e got, input erdma_use_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t streams used look like %s, expected %s", $time, got.name(),
               exp.name());
      stop_run();
    end
  endtask

  task automatic check_count(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t request address is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  // memory contents, 8 bytes per word
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a, input int i);
    logic [ADDR_W-1:0] p;
    p = a + ADDR_W'(i) * 32'd8;
    return {p * 32'h0001_0003 + 32'h1357_9bdf, p ^ 32'h5a5a_0f0f};
  endfunction

  // reference model of the unpack rules
  function automatic void build_expected(input erdma_use_e use_m, input int w, input int h,
                                         input logic [ADDR_W-1:0] b,
                                         input logic [ADDR_W-1:0] s);
    logic [DATA_W-1:0] word;
    for (int l = 0; l < h; l++) begin
      for (int i = 0; i < w; i++) begin
        word = mem_word(b + ADDR_W'(l) * s, i);
        case (use_m)
          USE_ALU: begin
            exp_alu.push_back(word[HALF_W-1:0]);
            exp_alu.push_back(word[DATA_W-1:HALF_W]);
          end
          USE_MUL: begin
            exp_mul.push_back(word[HALF_W-1:0]);
            exp_mul.push_back(word[DATA_W-1:HALF_W]);
          end
          default: begin
            exp_alu.push_back(word[HALF_W-1:0]);
            exp_mul.push_back(word[DATA_W-1:HALF_W]);
          end
        endcase
      end
    end
  endfunction

  function automatic erdma_use_e stream_use(input int a, input int m);
    if (a > 0 && m > 0) begin
      return USE_BOTH;
    end else if (a > 0) begin
      return USE_ALU;
    end
    return USE_MUL;
  endfunction

  // ======================================================================
  // memory model and ready drivers
  // ======================================================================
  always @(posedge nvdla_core_clk) begin : mem_model
    logic [ADDR_W-1:0] req_addr;
    int                req_words;
    logic              b0;
    logic              b1;
    if (!nvdla_core_rstn) begin
      rd_rsp_valid <= 1'b0;
      rd_req_ready <= 1'b0;
      alu_ready    <= 1'b0;
      mul_ready    <= 1'b0;
    end else begin
      if (op_en) begin
        req_line = 0;                          // new layer
      end
      if (rd_req_valid && rd_req_ready) begin
        req_addr  = rd_req_pd[ADDR_W-1:0];
        req_words = int'(rd_req_pd[REQ_W-1:ADDR_W]);
        check_addr(req_addr, base_addr + ADDR_W'(req_line) * line_stride);
        check_count("request word count", 32'(req_words), 32'(width));
        if (outstanding + req_words > LAT_DEPTH) begin
          report_fault("outstanding read words exceed the latency FIFO depth");
        end
        outstanding = outstanding + req_words;
        for (int i = 0; i < req_words; i++) begin
          pending.push_back(mem_word(req_addr, i));
        end
        req_line++;
      end
      if (rd_cdt_lat_fifo_pop) begin
        outstanding--;                         // one credit back
      end
      b0 = rand_bit();
      if (b0 && pending.size() != 0) begin
        rd_rsp_valid <= 1'b1;
        rd_rsp_pd    <= pending.pop_front();
      end else begin
        rd_rsp_valid <= 1'b0;                  // random gap
      end
      b0 = rand_bit();
      b1 = rand_bit();
      rd_req_ready <= hold_req ? (b0 & b1) : (b0 | b1);
      if (out_rand) begin
        alu_ready <= rand_bit();
        mul_ready <= rand_bit();
      end else begin
        alu_ready <= 1'b1;
        mul_ready <= 1'b1;
      end
    end
  end

  // ======================================================================
  // compare
  // ======================================================================
  always @(negedge nvdla_core_clk) begin : compare
    if (nvdla_core_rstn) begin
      if (op_en) begin
        build_expected(data_use, int'(width), int'(height), base_addr, line_stride);
        tb_stall = 0;
        alu_seen = 0;
        mul_seen = 0;
      end
      if (alu_valid) begin
        alu_seen++;                            // silent stream never raises valid
      end
      if (mul_valid) begin
        mul_seen++;
      end
      if (alu_valid && alu_ready) begin
        if (exp_alu.size() == 0) begin
          report_fault("ALU operand beat with no operand expected");
        end else begin
          check_operand("alu", alu_pd, exp_alu.pop_front());
        end
      end
      if (mul_valid && mul_ready) begin
        if (exp_mul.size() == 0) begin
          report_fault("MUL operand beat with no operand expected");
        end else begin
          check_operand("mul", mul_pd, exp_mul.pop_front());
        end
      end
      if (perf_dma_en && rd_req_valid && !rd_req_ready) begin
        tb_stall++;
      end
      if (rd_rsp_valid && !rd_rsp_ready) begin
        report_fault("read response refused by the latency FIFO");
      end
      if (erdma_top_inst.u_erdma_assertions.fail_cnt != 0) begin
        report_fault("a handshake assertion failed");
      end
      if (done) begin
        check_count("done pulses", 32'(done_cnt + 1), 32'(layers_started));
        check_count("alu operands still expected", 32'(exp_alu.size()), 32'd0);
        check_count("mul operands still expected", 32'(exp_mul.size()), 32'd0);
        check_use(stream_use(alu_seen, mul_seen), data_use);
        check_count("stall count", stall_cnt, 32'(tb_stall));
        done_cnt++;
      end
    end
  end

  // ======================================================================
  // clock, stimulus, watchdog
  // ======================================================================
  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    repeat (16 + TIMEOUT_CYCLES) @(posedge nvdla_core_clk);
    $display("timeout: the layers did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_run();
  end

  task automatic run_layer(input erdma_use_e use_m, input int w, input int h,
                           input logic [ADDR_W-1:0] b, input logic [ADDR_W-1:0] s,
                           input logic ro, input logic pf, input logic wh);
    @(posedge nvdla_core_clk);
    data_use    <= use_m;
    width       <= DIM_W'(w);
    height      <= DIM_W'(h);
    base_addr   <= b;
    line_stride <= s;
    perf_dma_en <= pf;
    out_rand    <= ro;
    hold_req    <= wh;
    @(posedge nvdla_core_clk);
    op_en <= 1'b1;
    layers_started++;
    @(posedge nvdla_core_clk);
    op_en <= 1'b0;
    while (done_cnt < layers_started) begin
      @(posedge nvdla_core_clk);
    end
  endtask

  initial begin
    nvdla_core_rstn = 1'b0;
    op_en           = 1'b0;
    data_use        = USE_ALU;
    perf_dma_en     = 1'b0;
    base_addr       = '0;
    line_stride     = '0;
    width           = '0;
    height          = '0;
    out_rand        = 1'b0;
    hold_req        = 1'b0;
    repeat (16) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    run_layer(USE_ALU,  4,  3, 32'h0000_1000, 32'h0000_0100, 1'b0, 1'b0, 1'b0);
    run_layer(USE_MUL,  4,  3, 32'h0000_2000, 32'h0000_0040, 1'b0, 1'b0, 1'b0);
    run_layer(USE_BOTH, 8,  4, 32'h0000_3000, 32'h0000_0080, 1'b1, 1'b0, 1'b0);
    run_layer(USE_BOTH, 16, 3, 32'h0000_4000, 32'h0000_0200, 1'b1, 1'b1, 1'b1);
    run_layer(USE_ALU,  32, 2, 32'h0000_5000, 32'h0000_0100, 1'b1, 1'b1, 1'b0);

    repeat (20) @(posedge nvdla_core_clk);     // catch any late done
    check_count("layers finished", 32'(done_cnt), 32'(layers_started));
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
verilog/erdma_pkg.sv
verilog/erdma_fifo.sv
verilog/erdma_ig.sv
verilog/erdma_eg.sv
verilog/erdma_top.sv
verif/erdma_assertions.sv
verif/erdma_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module erdma_tb \
  --Mdir obj_dir -o erdma_sim \
  -f vlog.f

# a failing run still leaves its log for the search below
./obj_dir/erdma_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
